/* tb.f */
src/char_pkg.sv
src/char_motion_if.sv
src/char_kin_if.sv
src/char_step_timer.sv
src/char_motion_fsm.sv
src/char_wall_detect.sv
src/char_physics.sv
src/char_top.sv
verification/tb_char.sv

/* run_sim.sh */
#!/bin/sh
# build and run tb_char with Verilator; exit status is non-zero when the log reports a failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_char -f tb.f -o tb_char_sim
./obj_dir/tb_char_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"

/* verification/tb_char.sv */
// directed tests only, buttons held as a player would; the run is cut off after 40000 sys_clk cycles
`timescale 1ns/1ps

module tb_char;
    import char_pkg::*;

    localparam int MAX_CYCLES = 40000;  // about twice the summed worst-case waits

    logic        sys_clk;
    logic        sys_rst_n;
    logic        left_btn;
    logic        right_btn;
    logic        jump_btn;
    phy_t        pos_x;
    phy_t        pos_y;
    phy_t        vel_x;
    phy_t        vel_y;
    face_t       face;
    char_state_e char_state;
    cnt_t        jump_cnt;
    logic        on_ground;

    int cycle_cnt = 0;
    int err_cnt = 0;
    int pass_tests = 0;
    int fail_tests = 0;

    char_top u_dut (.*);

    initial sys_clk = 1'b0;
    always #20 sys_clk = ~sys_clk;  // 40 ns period

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("run stopped: cycle limit of %0d reached before the tests ended", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic check_eq(input int actual, input int expected, input string msg);
        if (actual != expected) begin
            $display("FAIL %0d ns: %s, got %0d, expected %0d", $time, msg, actual, expected);
            err_cnt++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0d ns: %s did not happen in time", $time, what);
        err_cnt++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_tests++;
            $display("%s: passed", name);
        end else begin
            fail_tests++;
            $display("%s: failed", name);
        end
    endtask

    task automatic set_buttons(input logic left, input logic right, input logic jump);
        @(posedge sys_clk);
        left_btn  <= left;
        right_btn <= right;
        jump_btn  <= jump;
    endtask

    task automatic wait_state(input char_state_e s, input int limit_steps, input string what);
        int n;
        n = 0;
        do begin
            @(negedge sys_clk);  // outputs settle after the rising edge
            n++;
        end while (char_state != s && n < limit_steps * STEP_DIV);
        if (char_state != s) report_timeout(what);
    endtask

    // octal digits of the charge, each with its own weight, plus the two bias bits
    function automatic int jump_factor_of(input int cnt);
        int hi;
        int mid;
        int lo;
        hi  = (cnt / 64) % 8;
        mid = (cnt / 8) % 8;
        lo  = cnt % 8;
        return hi * 1024 + 512 + mid * 128 + 64 + lo * 32;
    endfunction

    // holds jump until jump_cnt reaches release_at, or until the FSM launches by itself
    task automatic charge_jump(input int release_at, output int last_charge,
                               output int launch_cnt);
        int prev;
        int n;
        set_buttons(1'b0, 1'b0, 1'b1);
        wait_state(CHARGE, 3, "entering CHARGE");
        last_charge = 1;  // every charge starts from one
        prev = jump_cnt;
        check_eq(prev, last_charge, "jump_cnt entering CHARGE");
        n = 0;
        while (char_state == CHARGE && n < 80 * STEP_DIV) begin
            if (jump_btn && jump_cnt >= release_at) set_buttons(1'b0, 1'b0, 1'b0);
            @(negedge sys_clk);
            n++;
            if (char_state == CHARGE && jump_cnt != prev) begin
                last_charge += CHARGE_INC;
                check_eq(jump_cnt, last_charge, "charge increment");
                prev = jump_cnt;
            end
        end
        if (char_state == CHARGE) report_timeout("leaving CHARGE");
        check_eq(char_state, JUMP, "state after CHARGE");
        launch_cnt = last_charge + CHARGE_INC;  // the last CHARGE step still adds
        check_eq(jump_cnt, launch_cnt, "jump_cnt at launch");
        if (jump_btn) set_buttons(1'b0, 1'b0, 1'b0);
    endtask

    task automatic wait_airborne(input string what);
        int n;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (pos_y == FLOOR_Y && n < 3 * STEP_DIV);
        if (pos_y == FLOOR_Y) report_timeout(what);
    endtask

    // pos_x must stay between the walls the whole flight
    task automatic wait_landing(input int limit_steps);
        int n;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
            check_eq(pos_x >= X_MIN && pos_x <= X_MAX, 1, "pos_x inside the playfield");
        end while (!(on_ground && pos_y == FLOOR_Y && vel_y == 0) && n < limit_steps * STEP_DIV);
        if (!(on_ground && pos_y == FLOOR_Y && vel_y == 0)) begin
            report_timeout("landing on the floor");
        end else begin
            check_eq(vel_x, 0, "vel_x after landing");
            check_eq(char_state, IDLE, "state after landing");
        end
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic test_reset();
        int base;
        base = err_cnt;
        @(negedge sys_clk);
        check_eq(char_state, IDLE, "state after reset");
        check_eq(face, 1, "face after reset");
        check_eq(jump_cnt, 1, "jump_cnt after reset");
        check_eq(vel_x, 0, "vel_x after reset");
        check_eq(vel_y, 0, "vel_y after reset");
        check_eq(pos_x, INIT_X, "pos_x after reset");
        check_eq(pos_y, FLOOR_Y, "pos_y after reset");
        check_eq(on_ground, 1, "on_ground after reset");
        finish_test("reset", base);
    endtask

    task automatic test_walk(input bit go_left);
        int base;
        int target;
        int dx;
        int d;
        int prev;
        int n;
        base   = err_cnt;
        target = go_left ? X_MAX : X_MIN;
        dx     = go_left ? WALK_STEP : -WALK_STEP;
        prev = pos_x;
        set_buttons(go_left, !go_left, 1'b0);
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
            d = pos_x - prev;
            if (d != 0 && pos_x == target) begin
                check_eq(d * dx > 0 && d * dx <= dx * dx, 1, "last walk step toward the wall");
            end else if (d != 0) begin
                check_eq(d, dx, "walk step");
            end
            prev = pos_x;
            check_eq(pos_y, FLOOR_Y, "pos_y while walking");
        end while (pos_x != target && n < 140 * STEP_DIV);
        if (pos_x != target) report_timeout("reaching the wall by walking");
        repeat (4 * STEP_DIV) begin  // keep pushing against the wall
            @(negedge sys_clk);
            check_eq(pos_x, target, "pos_x held at the wall");
        end
        check_eq(face, go_left ? 1 : -1, "face while walking");
        set_buttons(1'b0, 1'b0, 1'b0);
        wait_state(IDLE, 3, "return to IDLE after walking");
        finish_test(go_left ? "walk left" : "walk right", base);
    endtask

    task automatic test_short_jump();
        int base;
        int last;
        int launch;
        int f;
        int prev;
        int n;
        base = err_cnt;
        charge_jump(81, last, launch);
        f = jump_factor_of(launch);
        wait_airborne("lift-off of the short jump");
        check_eq(vel_y, (JUMP_VEL_Y + f) >>> SMOOTH_FACTOR, "vel_y at lift-off");
        prev = vel_y;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (vel_y == prev && n < 2 * STEP_DIV);
        check_eq(vel_y, (JUMP_VEL_Y + f + GRAVITY) >>> SMOOTH_FACTOR, "vel_y after gravity");
        wait_landing(80);
        finish_test("short jump", base);
    endtask

    task automatic test_full_charge();
        int base;
        int last;
        int launch;
        int expect_cnt;
        base = err_cnt;
        expect_cnt = 1;
        while (expect_cnt < MAX_CHARGE) expect_cnt += CHARGE_INC;  // first count at the limit
        charge_jump(1 << 20, last, launch);
        check_eq(last, expect_cnt, "jump_cnt when CHARGE ended");
        wait_airborne("lift-off of the full jump");
        wait_landing(120);
        finish_test("full charge", base);
    endtask

    task automatic test_side_bounce();
        int base;
        int last;
        int launch;
        int n;
        base = err_cnt;
        charge_jump(1 << 20, last, launch);
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (!(pos_x == X_MAX && vel_x > 0) && n < 3 * STEP_DIV);
        if (!(pos_x == X_MAX && vel_x > 0)) report_timeout("jump into the wall at X_MAX");
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (vel_x > 0 && n < 3 * STEP_DIV);
        if (vel_x > 0) report_timeout("bounce off the wall");
        check_eq(face, -1, "face after the bounce");
        wait_landing(120);
        finish_test("side bounce", base);
    endtask

    initial begin
        sys_rst_n = 1'b0;
        left_btn  = 1'b0;
        right_btn = 1'b0;
        jump_btn  = 1'b0;
        repeat (5) @(posedge sys_clk);
        sys_rst_n <= 1'b1;

        test_reset();
        test_short_jump();
        test_walk(1'b0);    // ends at X_MIN facing right
        test_full_charge();
        test_walk(1'b1);    // ends at X_MAX facing left
        test_side_bounce();

        $display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* src/char_top.sv */
// velocity outputs are whole pixels per step, truncated toward minus infinity
`timescale 1ns/1ps

module char_top (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  left_btn,
    input  logic                  right_btn,
    input  logic                  jump_btn,
    output char_pkg::phy_t        pos_x,
    output char_pkg::phy_t        pos_y,
    output char_pkg::phy_t        vel_x,
    output char_pkg::phy_t        vel_y,
    output char_pkg::face_t       face,
    output char_pkg::char_state_e char_state,
    output char_pkg::cnt_t        jump_cnt,
    output logic                  on_ground
);
    import char_pkg::*;

    logic step;
    logic floor_hit;
    logic side_hit;

    char_motion_if u_motion_if ();
    char_kin_if    u_kin_if ();

    char_step_timer u_step_timer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .step      (step)
    );

    char_motion_fsm u_motion_fsm (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .left_btn  (left_btn),
        .right_btn (right_btn),
        .jump_btn  (jump_btn),
        .step      (step),
        .on_ground (on_ground),
        .side_hit  (side_hit),
        .motion    (u_motion_if.fsm)
    );

    char_wall_detect u_wall_detect (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .kin       (u_kin_if.mon),
        .on_ground (on_ground),
        .floor_hit (floor_hit),
        .side_hit  (side_hit)
    );

    char_physics u_physics (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .motion    (u_motion_if.phys),
        .on_ground (on_ground),
        .floor_hit (floor_hit),
        .side_hit  (side_hit),
        .kin       (u_kin_if.phys)
    );

    assign pos_x      = u_kin_if.pos_x;
    assign pos_y      = u_kin_if.pos_y;
    assign vel_x      = u_kin_if.vel_x >>> SMOOTH_FACTOR;  // drop fraction bits
    assign vel_y      = u_kin_if.vel_y >>> SMOOTH_FACTOR;
    assign face       = u_motion_if.face;
    assign char_state = u_motion_if.state;
    assign jump_cnt   = u_motion_if.jump_cnt;

endmodule

/* src/char_physics.sv */
// one integration step per strobe; velocity limit keeps a step well under the wall spacing
`timescale 1ns/1ps

module char_physics (
    input  logic          sys_clk,
    input  logic          sys_rst_n,
    char_motion_if.phys   motion,
    input  logic          on_ground,
    input  logic          floor_hit,
    input  logic          side_hit,
    char_kin_if.phys      kin
);
    import char_pkg::*;

    phy_t jump_factor;
    phy_t vel_x_raw;
    phy_t vel_y_raw;
    phy_t vel_x_next;
    phy_t vel_y_next;
    phy_t walk_dx;
    phy_t pos_x_sum;
    phy_t pos_y_sum;
    phy_t pos_x_next;
    phy_t pos_y_next;
    phy_t vel_x_q;
    phy_t vel_y_q;
    phy_t pos_x_q;
    phy_t pos_y_q;

    function automatic phy_t clamp_vel(input phy_t v);
        if (v > MAX_VEL) begin
            return MAX_VEL;
        end else if (v < -MAX_VEL) begin
            return -MAX_VEL;
        end
        return v;
    endfunction

    //----------------------------------------------------------------------
    // jump strength, three octal digits of the charge with a bias
    //----------------------------------------------------------------------
    assign jump_factor = {4'b0, motion.jump_cnt[8:6], 1'b1, 9'b0}
                       + {7'b0, motion.jump_cnt[5:3], 1'b1, 6'b0}
                       + {9'b0, motion.jump_cnt[2:0], 5'b0};

    //----------------------------------------------------------------------
    // velocity
    //----------------------------------------------------------------------
    always_comb begin
        vel_x_raw = vel_x_q;
        vel_y_raw = vel_y_q;
        if (floor_hit) begin
            vel_x_raw = '0;  // landing kills all motion
            vel_y_raw = '0;
        end else if (side_hit) begin
            vel_x_raw = -(vel_x_q >>> 1);  // damped bounce
        end else if (motion.state == JUMP) begin
            vel_x_raw = (JUMP_VEL_X + (jump_factor >>> 2) + (jump_factor >>> 3)) * motion.face;
            vel_y_raw = JUMP_VEL_Y + jump_factor;
        end else if (!on_ground) begin
            vel_y_raw = vel_y_q + GRAVITY;
        end
    end

    assign vel_x_next = clamp_vel(vel_x_raw);
    assign vel_y_next = clamp_vel(vel_y_raw);

    //----------------------------------------------------------------------
    // position
    //----------------------------------------------------------------------
    always_comb begin
        case (motion.state)
            WALK_LEFT:  walk_dx = WALK_STEP;
            WALK_RIGHT: walk_dx = -WALK_STEP;
            default:    walk_dx = '0;
        endcase
    end

    assign pos_x_sum = pos_x_q + walk_dx + (vel_x_next >>> SMOOTH_FACTOR);
    assign pos_y_sum = pos_y_q + (vel_y_next >>> SMOOTH_FACTOR);

    assign pos_x_next = (pos_x_sum < X_MIN) ? X_MIN :
                        (pos_x_sum > X_MAX) ? X_MAX : pos_x_sum;
    assign pos_y_next = (pos_y_sum < FLOOR_Y) ? FLOOR_Y : pos_y_sum;  // no ceiling

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vel_x_q <= '0;
            vel_y_q <= '0;
            pos_x_q <= INIT_X;
            pos_y_q <= FLOOR_Y;
        end else if (motion.step) begin
            vel_x_q <= vel_x_next;
            vel_y_q <= vel_y_next;
            pos_x_q <= pos_x_next;
            pos_y_q <= pos_y_next;
        end
    end

    assign kin.pos_x = pos_x_q;
    assign kin.pos_y = pos_y_q;
    assign kin.vel_x = vel_x_q;
    assign kin.vel_y = vel_y_q;

endmodule

/* src/char_wall_detect.sv */
// flags lag the position by one sys_clk cycle; only the outer playfield walls are checked
`timescale 1ns/1ps

module char_wall_detect (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    char_kin_if.mon    kin,
    output logic       on_ground,
    output logic       floor_hit,
    output logic       side_hit
);
    import char_pkg::*;

    logic at_floor;
    logic at_x_min;
    logic at_x_max;

    // positions are clamped, so "at" also covers anything past the limit
    assign at_floor = (kin.pos_y <= FLOOR_Y);
    assign at_x_min = (kin.pos_x <= X_MIN);
    assign at_x_max = (kin.pos_x >= X_MAX);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            on_ground <= 1'b1;  // start standing
            floor_hit <= 1'b0;
            side_hit  <= 1'b0;
        end else begin
            on_ground <= at_floor && (kin.vel_y <= 0);
            floor_hit <= at_floor && (kin.vel_y < 0);  // still falling into the floor

            // only count a wall while still moving into it
            side_hit  <= (at_x_min && (kin.vel_x < 0)) ||
                         (at_x_max && (kin.vel_x > 0));
        end
    end

endmodule

/* src/char_motion_fsm.sv */
// buttons are assumed already debounced and synchronous to sys_clk; state only moves on step
`timescale 1ns/1ps

module char_motion_fsm (
    input  logic          sys_clk,
    input  logic          sys_rst_n,
    input  logic          left_btn,
    input  logic          right_btn,
    input  logic          jump_btn,
    input  logic          step,
    input  logic          on_ground,
    input  logic          side_hit,
    char_motion_if.fsm    motion
);
    import char_pkg::*;

    logic        left_q;
    logic        right_q;
    logic        jump_q;
    logic        jump_q2;
    logic        jump_rise;
    logic        jump_pend;  // latched jump request
    logic        max_charge;
    char_state_e state;
    char_state_e next_state;
    face_t       face;
    cnt_t        jump_cnt;

    //----------------------------------------------------------------------
    // button sampling
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            left_q  <= 1'b0;
            right_q <= 1'b0;
            jump_q  <= 1'b0;
            jump_q2 <= 1'b0;
        end else begin
            left_q  <= left_btn;
            right_q <= right_btn;
            jump_q  <= jump_btn;
            jump_q2 <= jump_q;
        end
    end

    assign jump_rise = jump_q & ~jump_q2;

    // an edge in mid-air is ignored, held until the jump is launched
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_pend <= 1'b0;
        end else if (jump_rise && on_ground) begin
            jump_pend <= 1'b1;
        end else if (state == JUMP) begin
            jump_pend <= 1'b0;
        end
    end

    //----------------------------------------------------------------------
    // movement FSM
    //----------------------------------------------------------------------
    assign max_charge = (jump_cnt >= MAX_CHARGE);

    always_comb begin
        next_state = IDLE;
        case (state)
            IDLE, WALK_LEFT, WALK_RIGHT: begin
                if (!on_ground) begin
                    next_state = IDLE;  // airborne, no steering
                end else if (left_q) begin
                    next_state = WALK_LEFT;
                end else if (right_q) begin
                    next_state = WALK_RIGHT;
                end else if (jump_pend) begin
                    next_state = CHARGE;
                end
            end
            CHARGE:  next_state = (max_charge || !jump_q) ? JUMP : CHARGE;
            JUMP:    next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= IDLE;
            jump_cnt <= cnt_t'(1);
            face     <= face_t'(1);
        end else if (step) begin
            state <= next_state;

            if (state == CHARGE) begin
                jump_cnt <= jump_cnt + CHARGE_INC;
            end else if (state == JUMP) begin
                jump_cnt <= cnt_t'(1);  // ready for the next charge
            end

            // wall bounce wins over walking direction
            if (side_hit) begin
                face <= -face;
            end else if (state == WALK_LEFT) begin
                face <= face_t'(1);
            end else if (state == WALK_RIGHT) begin
                face <= face_t'(-1);
            end
        end
    end

    assign motion.step     = step;
    assign motion.state    = state;
    assign motion.face     = face;
    assign motion.jump_cnt = jump_cnt;

endmodule

/* src/char_step_timer.sv */
// STEP_DIV must be at least 2; first strobe comes STEP_DIV cycles after reset release
`timescale 1ns/1ps

module char_step_timer (
    input  logic sys_clk,
    input  logic sys_rst_n,
    output logic step
);
    import char_pkg::*;

    logic [$clog2(STEP_DIV)-1:0] div_cnt;

    // free-running divider, strobe registered at the wrap
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            div_cnt <= '0;
            step    <= 1'b0;
        end else if (div_cnt == STEP_DIV - 1) begin
            div_cnt <= '0;
            step    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            step    <= 1'b0;  // high for a single cycle only
        end
    end

endmodule

/* src/char_kin_if.sv */
// velocities here are full fixed point; only the top level strips the fraction bits
`timescale 1ns/1ps

interface char_kin_if;
    import char_pkg::*;

    phy_t pos_x;  // whole pixels
    phy_t pos_y;
    phy_t vel_x;  // SMOOTH_FACTOR fraction bits
    phy_t vel_y;

    modport phys (
        output pos_x,
        output pos_y,
        output vel_x,
        output vel_y
    );

    // contact detection and monitoring
    modport mon (
        input pos_x,
        input pos_y,
        input vel_x,
        input vel_y
    );

endinterface

/* src/char_motion_if.sv */
// written only by the movement FSM; every field is stable between step pulses except step itself
`timescale 1ns/1ps

interface char_motion_if;
    import char_pkg::*;

    logic        step;      // one-cycle simulation strobe
    char_state_e state;
    face_t       face;
    cnt_t        jump_cnt;

    // FSM side drives everything
    modport fsm (
        output step,
        output state,
        output face,
        output jump_cnt
    );

    // physics only listens
    modport phys (
        input step,
        input state,
        input face,
        input jump_cnt
    );

endinterface

/* src/char_pkg.sv */
// all values are compile-time constants; velocities carry SMOOTH_FACTOR fraction bits, positions are whole pixels
package char_pkg;

    //----------------------------------------------------------------------
    // types
    //----------------------------------------------------------------------
    typedef logic signed [16:0] phy_t;   // velocity or position
    typedef logic signed [1:0]  face_t;  // +1 left, -1 right
    typedef logic [15:0]        cnt_t;   // jump charge

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        WALK_LEFT  = 3'd1,
        WALK_RIGHT = 3'd2,
        CHARGE     = 3'd3,
        JUMP       = 3'd4
    } char_state_e;

    //----------------------------------------------------------------------
    // timing and physics
    //----------------------------------------------------------------------
    localparam int STEP_DIV      = 16;  // sys_clk cycles per step, keep >= 2
    localparam int SMOOTH_FACTOR = 9;

    localparam phy_t GRAVITY    = -512;   // added to vel_y each airborne step
    localparam phy_t MAX_VEL    = 20480;  // 40 px per step
    localparam phy_t WALK_STEP  = 3;      // left increases x
    localparam phy_t JUMP_VEL_X = 1024;
    localparam phy_t JUMP_VEL_Y = 3072;

    localparam cnt_t MAX_CHARGE = 500;
    localparam cnt_t CHARGE_INC = 10;

    //----------------------------------------------------------------------
    // playfield and character
    //----------------------------------------------------------------------
    localparam phy_t CHAR_W   = 32;
    localparam phy_t PF_RIGHT = 560;  // inner edge of the right-hand wall
    localparam phy_t X_MIN    = 160;
    localparam phy_t X_MAX    = PF_RIGHT - CHAR_W;  // 528
    localparam phy_t FLOOR_Y  = 20;

    // start centred between the walls, standing on the floor
    localparam phy_t INIT_X = (X_MIN + X_MAX) / 2;  // 344

endpackage
